//--- hw/gray_pkg.sv
package gray_pkg;

    // channel and count widths
    typedef logic [9:0]  chan_t;
    typedef logic [10:0] luma_t;
    typedef logic [19:0] pix_cnt_t;
    typedef logic [15:0] frame_cnt_t;

    // one camera pixel, red in the top bits
    typedef struct packed {
        chan_t red;
        chan_t green;
        chan_t blue;
    } rgb_pixel_t;

    // binarized output pixel, original rgb carried along
    typedef struct packed {
        chan_t      color;
        logic       bw;
        rgb_pixel_t rgb;
        logic       last;
    } bin_pixel_t;

    // luma stage to binarize stage
    typedef struct packed {
        luma_t      luma;
        rgb_pixel_t rgb;
        logic       last;
    } luma_stage_t;

    // fixed luma weights, 19/64 + 75/128 + 37/256
    localparam logic [7:0] WEIGHT_RED   = 8'd19;
    localparam int         SHIFT_RED    = 6;
    localparam logic [7:0] WEIGHT_GREEN = 8'd75;
    localparam int         SHIFT_GREEN  = 7;
    localparam logic [7:0] WEIGHT_BLUE  = 8'd37;
    localparam int         SHIFT_BLUE   = 8;

    // register reset values
    localparam luma_t    THRESHOLD_RESET = 11'd600;
    localparam pix_cnt_t FRAME_LEN_RESET = 20'd307200;

    // register map, byte addresses
    localparam logic [3:0] ADDR_CTRL      = 4'h0;
    localparam logic [3:0] ADDR_THRESHOLD = 4'h4;
    localparam logic [3:0] ADDR_FRAME_LEN = 4'h8;
    localparam logic [3:0] ADDR_STATUS    = 4'hC;

    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    typedef enum logic [1:0] {
        S_IDLE,
        S_STREAM,
        S_WAIT
    } frame_state_t;

endpackage

//--- hw/gray_csr.sv
`timescale 1ns/1ps
module gray_csr (
    input  logic                  i_clk,
    input  logic                  i_arst_n,
    // axi4-lite write address / data / response
    input  logic [3:0]            i_awaddr,
    input  logic                  i_awvalid,
    output logic                  o_awready,
    input  logic [31:0]           i_wdata,
    input  logic [3:0]            i_wstrb,
    input  logic                  i_wvalid,
    output logic                  o_wready,
    output logic [1:0]            o_bresp,
    output logic                  o_bvalid,
    input  logic                  i_bready,
    // axi4-lite read
    input  logic [3:0]            i_araddr,
    input  logic                  i_arvalid,
    output logic                  o_arready,
    output logic [31:0]           o_rdata,
    output logic [1:0]            o_rresp,
    output logic                  o_rvalid,
    input  logic                  i_rready,
    // status from the sequencer
    input  logic                  i_busy,
    input  gray_pkg::frame_cnt_t  i_frame_cnt,
    // control to the datapath
    output logic                  o_start,
    output gray_pkg::luma_t       o_threshold,
    output gray_pkg::pix_cnt_t    o_frame_len
);
    import gray_pkg::*;

    logic        wr_fire;
    logic        rd_fire;
    logic        bvalid_r;
    logic        rvalid_r;
    logic [31:0] rdata_r;
    logic [31:0] rdata_w;
    logic        start_r;
    luma_t       threshold_r;
    pix_cnt_t    frame_len_r;

    // write only when aw and w meet and no response is pending
    assign wr_fire   = i_awvalid && i_wvalid && !bvalid_r;
    assign o_awready = wr_fire;
    assign o_wready  = wr_fire;
    assign o_bresp   = AXI_RESP_OKAY;
    assign o_bvalid  = bvalid_r;

    // one read in flight at a time
    assign rd_fire   = i_arvalid && !rvalid_r;
    assign o_arready = rd_fire;
    assign o_rresp   = AXI_RESP_OKAY;
    assign o_rvalid  = rvalid_r;
    assign o_rdata   = rdata_r;

    assign o_start     = start_r;
    assign o_threshold = threshold_r;
    assign o_frame_len = frame_len_r;

    // read mux, status sampled live
    always_comb begin
        rdata_w = '0;
        case (i_araddr)
            ADDR_THRESHOLD: rdata_w[10:0] = threshold_r;
            ADDR_FRAME_LEN: rdata_w[19:0] = frame_len_r;
            ADDR_STATUS: begin
                rdata_w[0]     = i_busy;
                rdata_w[31:16] = i_frame_cnt;
            end
            // ctrl is write only
            default: rdata_w = '0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            start_r     <= 1'b0;
            threshold_r <= THRESHOLD_RESET;
            frame_len_r <= FRAME_LEN_RESET;
            bvalid_r    <= 1'b0;
            rvalid_r    <= 1'b0;
        end else begin
            // self-clearing start
            start_r <= wr_fire && (i_awaddr == ADDR_CTRL) && i_wstrb[0] && i_wdata[0];
            if (wr_fire && (i_awaddr == ADDR_THRESHOLD)) begin
                if (i_wstrb[0]) threshold_r[7:0]  <= i_wdata[7:0];
                if (i_wstrb[1]) threshold_r[10:8] <= i_wdata[10:8];
            end
            if (wr_fire && (i_awaddr == ADDR_FRAME_LEN)) begin
                if (i_wstrb[0]) frame_len_r[7:0]   <= i_wdata[7:0];
                if (i_wstrb[1]) frame_len_r[15:8]  <= i_wdata[15:8];
                if (i_wstrb[2]) frame_len_r[19:16] <= i_wdata[19:16];
            end
            // response one cycle after the handshake
            if (wr_fire) begin
                bvalid_r <= 1'b1;
            end else if (i_bready) begin
                bvalid_r <= 1'b0;
            end
            if (rd_fire) begin
                rvalid_r <= 1'b1;
            end else if (i_rready) begin
                rvalid_r <= 1'b0;
            end
        end
    end

    // read data register
    always_ff @(posedge i_clk) begin
        if (rd_fire) begin
            rdata_r <= rdata_w;
        end
    end

    a_bvalid_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_bvalid && !i_bready |=> o_bvalid);

    // back-to-back writes are spaced by bvalid
    a_start_single: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_start |=> !o_start);

endmodule

//--- hw/gray_frame_ctrl.sv
`timescale 1ns/1ps
module gray_frame_ctrl (
    input  logic                  i_clk,
    input  logic                  i_arst_n,
    input  logic                  i_start,
    input  gray_pkg::pix_cnt_t    i_frame_len,
    input  logic                  i_pix_valid,
    input  logic                  i_pipe_advance,
    input  logic                  i_pipe_empty,
    output logic                  o_pix_ready,
    output logic                  o_pix_accept,
    output logic                  o_pix_last,
    output logic                  o_read_req,
    output logic                  o_vga_start,
    output logic                  o_busy,
    output gray_pkg::frame_cnt_t  o_frame_cnt
);
    import gray_pkg::*;

    frame_state_t state_r, state_w;
    pix_cnt_t     count_r, count_w;
    frame_cnt_t   frame_cnt_r, frame_cnt_w;
    logic         read_req_r, read_req_w;
    logic         vga_start_r, vga_start_w;
    logic         first_frame_r, first_frame_w;

    // ready only while streaming and the pipe moves
    assign o_pix_ready  = (state_r == S_STREAM) && i_pipe_advance;
    assign o_pix_accept = o_pix_ready && i_pix_valid;
    // final pixel of the frame
    assign o_pix_last   = o_pix_accept && (count_r == i_frame_len - 20'd1);
    assign o_read_req   = read_req_r;
    assign o_vga_start  = vga_start_r;
    assign o_busy       = (state_r != S_IDLE);
    assign o_frame_cnt  = frame_cnt_r;

    always_comb begin
        state_w       = state_r;
        count_w       = count_r;
        frame_cnt_w   = frame_cnt_r;
        first_frame_w = first_frame_r;
        // pulses default low
        read_req_w    = 1'b0;
        vga_start_w   = 1'b0;

        case (state_r)
            S_IDLE: begin
                if (i_start) begin
                    state_w       = S_STREAM;
                    count_w       = '0;
                    read_req_w    = 1'b1;
                    // display starts once after reset
                    vga_start_w   = first_frame_r;
                    first_frame_w = 1'b0;
                end
            end
            S_STREAM: begin
                if (o_pix_accept) begin
                    count_w = count_r + 20'd1;
                    if (o_pix_last) begin
                        state_w = S_WAIT;
                    end
                end
            end
            S_WAIT: begin
                // drain both stages before closing the frame
                if (i_pipe_empty) begin
                    state_w     = S_IDLE;
                    frame_cnt_w = frame_cnt_r + 16'd1;
                end
            end
            default: state_w = S_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_r       <= S_IDLE;
            count_r       <= '0;
            frame_cnt_r   <= '0;
            read_req_r    <= 1'b0;
            vga_start_r   <= 1'b0;
            first_frame_r <= 1'b1;
        end else begin
            state_r       <= state_w;
            count_r       <= count_w;
            frame_cnt_r   <= frame_cnt_w;
            read_req_r    <= read_req_w;
            vga_start_r   <= vga_start_w;
            first_frame_r <= first_frame_w;
        end
    end

    // accepts stay inside the streaming window and below the frame length
    a_accept_in_stream: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_pix_accept |-> (state_r == S_STREAM) && (count_r < i_frame_len));

endmodule

//--- hw/gray_luma.sv
`timescale 1ns/1ps
module gray_luma (
    input  logic                   i_clk,
    input  logic                   i_arst_n,
    input  logic                   i_en,
    input  logic                   i_valid,
    input  gray_pkg::rgb_pixel_t   i_pix,
    input  logic                   i_last,
    output gray_pkg::luma_stage_t  o_stage,
    output logic                   o_valid
);
    import gray_pkg::*;

    // 10-bit channel times 8-bit weight
    logic [17:0] red_prod;
    logic [17:0] green_prod;
    logic [17:0] blue_prod;
    luma_t       red_term;
    luma_t       green_term;
    luma_t       blue_term;
    luma_stage_t stage_w;
    luma_stage_t stage_r;
    logic        valid_r;

    always_comb begin
        red_prod   = i_pix.red * WEIGHT_RED;
        green_prod = i_pix.green * WEIGHT_GREEN;
        blue_prod  = i_pix.blue * WEIGHT_BLUE;
        // after the shift each term is below 600
        red_term   = luma_t'(red_prod >> SHIFT_RED);
        green_term = luma_t'(green_prod >> SHIFT_GREEN);
        blue_term  = luma_t'(blue_prod >> SHIFT_BLUE);
        // max sum 1049, fits in 11 bits
        stage_w.luma = red_term + green_term + blue_term;
        stage_w.rgb  = i_pix;
        stage_w.last = i_last;
    end

    assign o_stage = stage_r;
    assign o_valid = valid_r;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid_r <= 1'b0;
        end else if (i_en) begin
            valid_r <= i_valid;
        end
    end

    // payload, held while stalled
    always_ff @(posedge i_clk) begin
        if (i_en) begin
            stage_r <= stage_w;
        end
    end

endmodule

//--- hw/gray_binarize.sv
`timescale 1ns/1ps
module gray_binarize (
    input  logic                   i_clk,
    input  logic                   i_arst_n,
    input  gray_pkg::luma_stage_t  i_stage,
    input  logic                   i_valid,
    input  gray_pkg::luma_t        i_threshold,
    input  logic                   i_out_ready,
    output gray_pkg::bin_pixel_t   o_out,
    output logic                   o_out_valid,
    output logic                   o_advance,
    output logic                   o_empty
);
    import gray_pkg::*;

    logic       bright;
    bin_pixel_t out_w;
    bin_pixel_t out_r;
    logic       out_valid_r;

    // output register free or being drained
    assign o_advance   = !out_valid_r || i_out_ready;
    // nothing in either stage
    assign o_empty     = !out_valid_r && !i_valid;
    assign o_out       = out_r;
    assign o_out_valid = out_valid_r;

    always_comb begin
        // strictly above threshold is white
        bright      = (i_stage.luma > i_threshold);
        out_w.color = bright ? '1 : '0;
        out_w.bw    = !bright;
        out_w.rgb   = i_stage.rgb;
        out_w.last  = i_stage.last;
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            out_valid_r <= 1'b0;
        end else if (o_advance) begin
            out_valid_r <= i_valid;
        end
    end

    // payload register
    always_ff @(posedge i_clk) begin
        if (o_advance) begin
            out_r <= out_w;
        end
    end

    // stalled output holds both data and valid
    a_out_stable: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_out_valid && !i_out_ready |=> o_out_valid && $stable(o_out));

endmodule

//--- hw/gray_top.sv
`timescale 1ns/1ps
module gray_top (
    input  logic                  i_clk,
    input  logic                  i_arst_n,
    // axi4-lite slave
    input  logic [3:0]            i_awaddr,
    input  logic                  i_awvalid,
    output logic                  o_awready,
    input  logic [31:0]           i_wdata,
    input  logic [3:0]            i_wstrb,
    input  logic                  i_wvalid,
    output logic                  o_wready,
    output logic [1:0]            o_bresp,
    output logic                  o_bvalid,
    input  logic                  i_bready,
    input  logic [3:0]            i_araddr,
    input  logic                  i_arvalid,
    output logic                  o_arready,
    output logic [31:0]           o_rdata,
    output logic [1:0]            o_rresp,
    output logic                  o_rvalid,
    input  logic                  i_rready,
    // pixel streams
    input  gray_pkg::rgb_pixel_t  i_pix,
    input  logic                  i_pix_valid,
    output logic                  o_pix_ready,
    output gray_pkg::bin_pixel_t  o_out,
    output logic                  o_out_valid,
    input  logic                  i_out_ready,
    // sdram request and vga start
    output logic                  o_read_req,
    output logic                  o_vga_start
);
    import gray_pkg::*;

    logic        start;
    luma_t       threshold;
    pix_cnt_t    frame_len;
    logic        busy;
    frame_cnt_t  frame_cnt;
    logic        pix_accept;
    logic        pix_last;
    logic        pipe_advance;
    logic        pipe_empty;
    luma_stage_t luma_stage;
    logic        luma_valid;

    gray_csr u_csr (
        .i_clk(i_clk), .i_arst_n(i_arst_n),
        .i_awaddr(i_awaddr), .i_awvalid(i_awvalid), .o_awready(o_awready),
        .i_wdata(i_wdata), .i_wstrb(i_wstrb), .i_wvalid(i_wvalid), .o_wready(o_wready),
        .o_bresp(o_bresp), .o_bvalid(o_bvalid), .i_bready(i_bready),
        .i_araddr(i_araddr), .i_arvalid(i_arvalid), .o_arready(o_arready),
        .o_rdata(o_rdata), .o_rresp(o_rresp), .o_rvalid(o_rvalid), .i_rready(i_rready),
        .i_busy(busy), .i_frame_cnt(frame_cnt),
        .o_start(start), .o_threshold(threshold), .o_frame_len(frame_len)
    );

    gray_frame_ctrl u_frame_ctrl (
        .i_clk(i_clk), .i_arst_n(i_arst_n),
        .i_start(start), .i_frame_len(frame_len), .i_pix_valid(i_pix_valid),
        .i_pipe_advance(pipe_advance), .i_pipe_empty(pipe_empty),
        .o_pix_ready(o_pix_ready), .o_pix_accept(pix_accept), .o_pix_last(pix_last),
        .o_read_req(o_read_req), .o_vga_start(o_vga_start),
        .o_busy(busy), .o_frame_cnt(frame_cnt)
    );

    // stage 1, weighted sum
    gray_luma u_luma (
        .i_clk(i_clk), .i_arst_n(i_arst_n),
        .i_en(pipe_advance), .i_valid(pix_accept), .i_pix(i_pix), .i_last(pix_last),
        .o_stage(luma_stage), .o_valid(luma_valid)
    );

    // stage 2, threshold and output register
    gray_binarize u_binarize (
        .i_clk(i_clk), .i_arst_n(i_arst_n),
        .i_stage(luma_stage), .i_valid(luma_valid), .i_threshold(threshold),
        .i_out_ready(i_out_ready),
        .o_out(o_out), .o_out_valid(o_out_valid),
        .o_advance(pipe_advance), .o_empty(pipe_empty)
    );

endmodule

//--- sim/tb_gray_top.sv
`timescale 1ns/1ps
module tb_gray_top;
    import gray_pkg::*;

    localparam int FRAME_PIX = 48;
    localparam int FRAMES    = 3;
    // about 4 cycles per pixel with random gaps plus 924 for register traffic, times 4
    localparam int CYCLE_LIMIT = 4 * (FRAMES * FRAME_PIX * 4 + 924);

    logic i_clk, i_arst_n;
    logic [3:0] i_awaddr, i_araddr, i_wstrb;
    logic [31:0] i_wdata, o_rdata;
    logic [1:0] o_bresp, o_rresp;
    logic i_awvalid, o_awready, i_wvalid, o_wready, o_bvalid, i_bready;
    logic i_arvalid, o_arready, o_rvalid, i_rready;
    rgb_pixel_t i_pix;
    bin_pixel_t o_out;
    logic i_pix_valid, o_pix_ready, o_out_valid, i_out_ready;
    logic o_read_req, o_vga_start;

    int seed = 90864;
    int errors = 0;
    int cycles = 0;
    int out_count = 0;
    int frame_accepts = 0;
    int req_count = 0;
    int vga_count = 0;
    int cur_threshold = 600;
    // reference queue with its head mirrored for the assertions
    bin_pixel_t exp_q[$];
    bin_pixel_t exp_head = '0;
    logic exp_avail = 1'b0;
    rgb_pixel_t frame_pix [FRAME_PIX];

    gray_top UUT (.*);

    initial i_clk = 1'b0;
    always #10 i_clk = ~i_clk;

    // hard stop
    always @(posedge i_clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, run did not finish", cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    function automatic logic coin_flip();
        return ($random(seed) % 2) == 0;
    endfunction

    // weighted luma from the fixed weights with each term truncated
    function automatic int luma_of(input rgb_pixel_t pix);
        return ((int'(pix.red) * int'(WEIGHT_RED)) >> SHIFT_RED)
             + ((int'(pix.green) * int'(WEIGHT_GREEN)) >> SHIFT_GREEN)
             + ((int'(pix.blue) * int'(WEIGHT_BLUE)) >> SHIFT_BLUE);
    endfunction

    function automatic bin_pixel_t expect_pixel(input rgb_pixel_t pix, input int threshold,
                                                input logic last);
        bin_pixel_t res;
        logic white;
        white     = luma_of(pix) > threshold;
        res.color = white ? 10'h3FF : 10'h000;
        res.bw    = !white;
        res.rgb   = pix;
        res.last  = last;
        return res;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual == expected) else begin
            $display("mismatch %s expected %h got %h", name, expected, actual);
            errors = errors + 1;
        end
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
        i_awaddr  <= addr;
        i_wdata   <= data;
        i_wstrb   <= 4'hF;
        i_awvalid <= 1'b1;
        i_wvalid  <= 1'b1;
        do @(posedge i_clk); while (!(o_awready && o_wready));
        i_awvalid <= 1'b0;
        i_wvalid  <= 1'b0;
        i_bready  <= 1'b1;
        do @(posedge i_clk); while (!o_bvalid);
        check_value("o_bresp", AXI_RESP_OKAY, o_bresp);
        i_bready <= 1'b0;
    endtask

    task automatic read_reg(input logic [3:0] addr, output logic [31:0] data);
        i_araddr  <= addr;
        i_arvalid <= 1'b1;
        do @(posedge i_clk); while (!o_arready);
        i_arvalid <= 1'b0;
        i_rready  <= 1'b1;
        do @(posedge i_clk); while (!o_rvalid);
        data = o_rdata;
        check_value("o_rresp", AXI_RESP_OKAY, o_rresp);
        i_rready <= 1'b0;
    endtask

    // first pixel with the wanted luma and with red and blue at either end
    task automatic pick_pixel(input int target, output rgb_pixel_t pix);
        rgb_pixel_t cand;
        logic found;
        found = 1'b0;
        pix   = '0;
        for (int r = 0; r < 2; r++) begin
            for (int b = 0; b < 2; b++) begin
                for (int g = 0; g < 1024; g++) begin
                    cand = {(r != 0) ? 10'h3FF : 10'h000, 10'(g),
                            (b != 0) ? 10'h3FF : 10'h000};
                    if (!found && luma_of(cand) == target) begin
                        pix   = cand;
                        found = 1'b1;
                    end
                end
            end
        end
        if (!found) begin
            $display("no pixel found with luma %0d", target);
            errors = errors + 1;
        end
    endtask

    // pixel source with random valid gaps and valid held until taken
    task automatic send_frame();
        int idx;
        idx = 0;
        i_pix       <= frame_pix[0];
        i_pix_valid <= coin_flip();
        while (idx < FRAME_PIX) begin
            @(posedge i_clk);
            if (i_pix_valid && o_pix_ready) begin
                idx = idx + 1;
            end
            if (idx < FRAME_PIX) begin
                i_pix <= frame_pix[idx];
                if (!i_pix_valid || o_pix_ready) begin
                    i_pix_valid <= coin_flip();
                end
            end else begin
                // surplus pixel offered past the frame end
                i_pix       <= frame_pix[0];
                i_pix_valid <= 1'b1;
            end
        end
        repeat (8) @(posedge i_clk);
        i_pix_valid <= 1'b0;
    endtask

    task automatic run_frame(input int threshold, input int frame_no, input logic poke_busy);
        logic [31:0] status;
        write_reg(ADDR_THRESHOLD, threshold);
        cur_threshold = threshold;
        // luma right at the threshold and then one above
        pick_pixel(threshold, frame_pix[0]);
        pick_pixel(threshold + 1, frame_pix[1]);
        for (int i = 2; i < FRAME_PIX; i++) begin
            frame_pix[i] = {10'($random(seed)), 10'($random(seed)), 10'($random(seed))};
        end
        write_reg(ADDR_CTRL, 32'h1);
        fork
            send_frame();
            if (poke_busy) begin
                // second start mid-frame that must be dropped
                repeat (12) @(posedge i_clk);
                write_reg(ADDR_CTRL, 32'h1);
            end
        join
        status = 32'h1;
        while (status[0]) begin
            read_reg(ADDR_STATUS, status);
        end
        check_value("status frame count", frame_no, status[31:16]);
        check_value("pixels accepted", FRAME_PIX, frame_accepts);
    endtask

    // output sink with random stalls
    initial begin
        i_out_ready = 1'b0;
        forever begin
            @(posedge i_clk);
            i_out_ready <= coin_flip();
        end
    end

    // reference model fed from input transfers
    always @(posedge i_clk) begin
        int base;
        if (i_arst_n) begin
            base = o_read_req ? 0 : frame_accepts;
            if (o_out_valid && i_out_ready && exp_q.size() > 0) begin
                void'(exp_q.pop_front());
                out_count <= out_count + 1;
            end
            if (i_pix_valid && o_pix_ready) begin
                exp_q.push_back(expect_pixel(i_pix, cur_threshold, base == FRAME_PIX - 1));
                frame_accepts <= base + 1;
            end else if (o_read_req) begin
                frame_accepts <= 0;
            end
            if (o_read_req) req_count <= req_count + 1;
            if (o_vga_start) vga_count <= vga_count + 1;
            exp_avail <= exp_q.size() > 0;
            if (exp_q.size() > 0) exp_head <= exp_q[0];
        end
    end

    a_out_expected: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_out_valid && i_out_ready |-> exp_avail)
        else begin
            $display("output pixel arrived with none expected");
            errors = errors + 1;
        end

    a_out_match: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_out_valid && i_out_ready && exp_avail |-> o_out == exp_head)
        else begin
            $display("mismatch o_out expected %h got %h", $sampled(exp_head), $sampled(o_out));
            errors = errors + 1;
        end

    a_out_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_out_valid && !i_out_ready |=> o_out_valid && $stable(o_out))
        else begin
            $display("output changed while stalled");
            errors = errors + 1;
        end

    a_read_req_pulse: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_read_req |=> !o_read_req)
        else begin
            $display("read request high for more than one cycle");
            errors = errors + 1;
        end

    // display start only with the very first read request
    a_vga_first: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_vga_start |-> o_read_req && req_count == 0)
        else begin
            $display("display start outside the first frame");
            errors = errors + 1;
        end

    a_frame_limit: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_pix_valid && o_pix_ready |-> o_read_req || frame_accepts < FRAME_PIX)
        else begin
            $display("pixel accepted beyond the frame length");
            errors = errors + 1;
        end

    a_ready_after_frame: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        frame_accepts == FRAME_PIX && !o_read_req |-> !o_pix_ready)
        else begin
            $display("pixel ready high after the frame ended");
            errors = errors + 1;
        end

    initial begin
        logic [31:0] rdata;
        i_arst_n    = 1'b0;
        i_awaddr    = '0;
        i_awvalid   = 1'b0;
        i_wdata     = '0;
        i_wstrb     = '0;
        i_wvalid    = 1'b0;
        i_bready    = 1'b0;
        i_araddr    = '0;
        i_arvalid   = 1'b0;
        i_rready    = 1'b0;
        i_pix       = '0;
        i_pix_valid = 1'b0;
        repeat (3) @(posedge i_clk);
        i_arst_n <= 1'b1;
        @(posedge i_clk);
        check_value("idle outputs", 0,
                    {o_read_req, o_vga_start, o_pix_ready, o_out_valid, o_bvalid, o_rvalid});

        // register block
        read_reg(ADDR_THRESHOLD, rdata);
        check_value("threshold reset", 600, rdata);
        read_reg(ADDR_FRAME_LEN, rdata);
        check_value("frame_len reset", 307200, rdata);
        write_reg(ADDR_THRESHOLD, 32'h0000_0555);
        read_reg(ADDR_THRESHOLD, rdata);
        check_value("threshold", 32'h555, rdata);
        write_reg(ADDR_FRAME_LEN, FRAME_PIX);
        read_reg(ADDR_FRAME_LEN, rdata);
        check_value("frame_len", FRAME_PIX, rdata);
        write_reg(ADDR_STATUS, 32'hFFFF_FFFF);
        read_reg(ADDR_STATUS, rdata);
        check_value("status", 0, rdata);
        read_reg(ADDR_CTRL, rdata);
        check_value("ctrl", 0, rdata);

        // three frames with a new threshold each time
        run_frame(600, 1, 1'b0);
        run_frame(300, 2, 1'b1);
        run_frame(900, 3, 1'b0);

        check_value("read_req pulses", FRAMES, req_count);
        check_value("vga_start pulses", 1, vga_count);
        check_value("pixels out", FRAMES * FRAME_PIX, out_count);
        check_value("pending pixels", 0, exp_q.size());

        $display("errors: %0d, pixels checked: %0d, cycles: %0d", errors, out_count, cycles);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
hw/gray_pkg.sv
hw/gray_csr.sv
hw/gray_frame_ctrl.sv
hw/gray_luma.sv
hw/gray_binarize.sv
hw/gray_top.sv
sim/tb_gray_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with verilator, pass or fail from the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_gray_top -f verilog.f -o tb_gray_top
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_gray_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
    exit 1
fi
exit 0
